// ==== dv/dbg_props.sv ====
module dbg_props (
    input logic clk,
    input logic rst_n_i,
    input logic running_i,
    input logic halted_i,
    input logic resumereq_i,
    input logic resumeack_i,
    input logic pending_i,
    input logic done_i
);

    // exactly one run state at a time
    one_state: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(running_i && halted_i))
        else $error("core reports running and halted together");

    // an ack only comes from a resume request seen while halted
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        resumeack_i |-> $past(resumereq_i && halted_i))
        else $error("resumeack without a resume request from the halted state");

    done_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_i |-> pending_i)
        else $error("abstract access done without a pending access");

endmodule

// fsm side, access inputs tied idle
bind core_dbg_fsm dbg_props u_fsm_props (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .running_i   (core_running_o),
    .halted_i    (core_halted_o),
    .resumereq_i (resumereq_i),
    .resumeack_i (core_resumeack_o),
    .pending_i   (1'b0),
    .done_i      (1'b0)
);

// access side, run state inputs tied to a legal value
bind abstract_access dbg_props u_ar_props (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .running_i   (1'b1),
    .halted_i    (1'b0),
    .resumereq_i (1'b0),
    .resumeack_i (1'b0),
    .pending_i   (pending_q),
    .done_i      (done_q)
);

// ==== dv/dbg_tb.sv ====
`include "dbg_settings.svh"

module dbg_tb;

    localparam int TIMEOUT = 50;

    logic                 clk;
    logic                 rst_n_i;
    logic                 retire_valid_i;
    logic                 retire_ebreak_i;
    logic [4:0]           retire_rd_i;
    logic [`DBG_XLEN-1:0] retire_data_i;
    logic [`DBG_XLEN-1:0] retire_pc_i;
    logic [`DBG_XLEN-1:0] retire_next_pc_i;
    logic                 haltreq_i;
    logic                 resumereq_i;
    logic                 dbg_ar_en_i;
    logic                 dbg_ar_wr_i;
    logic [15:0]          dbg_ar_ad_i;
    logic [`DBG_XLEN-1:0] dbg_ar_do_i;
    logic [`DBG_XLEN-1:0] dbg_ar_di_o;
    logic                 dbg_ar_done_o;
    logic                 core_running_o;
    logic                 core_halted_o;
    logic                 core_resumeack_o;
    logic [`DBG_XLEN-1:0] resume_pc_o;

    integer               seed = 33444;
    int                   errors = 0;
    int                   timeouts = 0;
    // expected register contents
    logic [`DBG_XLEN-1:0] exp_gpr [`DBG_NUM_GPR] = '{default: '0};

    dbg_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [15:0] gpr_addr(input int n);
        return 16'(`DBG_GPR_BASE + n);
    endfunction

    // xdebugver in 31:28, cause in 8:6, prv in 1:0
    function automatic logic [31:0] dcsr_value(input logic [2:0] cause);
        logic [31:0] v;
        v = '0;
        v[31:28] = 4'(`DBG_XDEBUGVER);
        v[8:6] = cause;
        v[1:0] = 2'b11;
        return v;
    endfunction

    task automatic wait_done(input string name, output logic [31:0] data);
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(negedge clk);
            if (dbg_ar_done_o) begin
                break;
            end
            cycles++;
        end
        assert (cycles < TIMEOUT) else begin
            $display("%s: abstract access never signalled done", name);
            timeouts++;
        end
        data = dbg_ar_di_o;
    endtask

    task automatic ar_access(input string name, input logic wr, input logic [15:0] ad,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        dbg_ar_en_i <= 1'b1;
        dbg_ar_wr_i <= wr;
        dbg_ar_ad_i <= ad;
        dbg_ar_do_i <= wdata;
        @(posedge clk);
        dbg_ar_en_i <= 1'b0;
        wait_done(name, rdata);
    endtask

    task automatic read_check(input string name, input logic [15:0] ad,
                              input logic [31:0] exp);
        logic [31:0] rdata;
        ar_access(name, 1'b0, ad, '0, rdata);
        check_value(name, exp, rdata);
    endtask

    // one retire cycle, next pc is pc + 4
    task automatic retire(input logic ebreak, input logic [4:0] rd,
                          input logic [31:0] data, input logic [31:0] pc);
        @(posedge clk);
        retire_valid_i   <= 1'b1;
        retire_ebreak_i  <= ebreak;
        retire_rd_i      <= rd;
        retire_data_i    <= data;
        retire_pc_i      <= pc;
        retire_next_pc_i <= pc + 32'd4;
        @(posedge clk);
        retire_valid_i   <= 1'b0;
        retire_ebreak_i  <= 1'b0;
    endtask

    task automatic wait_halted(input string name, input logic halted);
        int cycles;
        cycles = 0;
        while (core_halted_o !== halted && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (core_halted_o === halted && core_running_o === !halted) else begin
            $display("%s: core did not reach the expected run state", name);
            timeouts++;
        end
    endtask

    task automatic halt_core(input string name);
        @(posedge clk);
        haltreq_i <= 1'b1;
        @(posedge clk);
        haltreq_i <= 1'b0;
        wait_halted(name, 1'b1);
    endtask

    // counts ack pulses in a short window after a one-cycle resume request
    task automatic resume_core(input string name, output int acks, output logic [31:0] pc);
        @(posedge clk);
        resumereq_i <= 1'b1;
        @(posedge clk);
        resumereq_i <= 1'b0;
        acks = 0;
        pc = '0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (core_resumeack_o) begin
                acks++;
                pc = resume_pc_o;
            end
        end
        wait_halted(name, 1'b0);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_value("test_reset status", 32'b1000,
                    {28'd0, core_running_o, core_halted_o, core_resumeack_o, dbg_ar_done_o});
        read_check("test_reset dcsr", `DBG_ADDR_DCSR, dcsr_value(3'd0));
        read_check("test_reset dpc", `DBG_ADDR_DPC, '0);
        read_check("test_reset unmapped", 16'h0123, '0);
    endtask

    task automatic test_retire_readback();
        int          regs [4] = '{0, 1, 7, 31};
        logic [31:0] data;
        foreach (regs[i]) begin
            data = $random(seed);
            retire(1'b0, 5'(regs[i]), data, 32'h80 + 32'(i * 4));
            if (regs[i] != 0) begin
                exp_gpr[regs[i]] = data;
            end
        end
        foreach (regs[i]) begin
            read_check($sformatf("test_retire_readback x%0d", regs[i]), gpr_addr(regs[i]),
                       exp_gpr[regs[i]]);
        end
    endtask

    task automatic test_gpr_write();
        logic [31:0] data;
        logic [31:0] rdata;
        logic [31:0] pc;
        int          acks;
        data = $random(seed);
        ar_access("test_gpr_write", 1'b1, gpr_addr(12), data, rdata);
        exp_gpr[12] = data;
        read_check("test_gpr_write x12", gpr_addr(12), exp_gpr[12]);
        halt_core("test_gpr_write");
        // halted, so both writes must be dropped
        retire(1'b0, 5'd12, ~data, 32'h300);
        retire(1'b0, 5'd1, ~exp_gpr[1], 32'h304);
        read_check("test_gpr_write halted x12", gpr_addr(12), exp_gpr[12]);
        read_check("test_gpr_write halted x1", gpr_addr(1), exp_gpr[1]);
        resume_core("test_gpr_write", acks, pc);
        check_value("test_gpr_write acks", 32'd1, 32'(acks));
        // last retire before the halt was at 0x8c
        check_value("test_gpr_write pc", 32'h90, pc);
    endtask

    task automatic test_halt_ebreak();
        logic [31:0] data;
        logic [31:0] pc;
        int          acks;
        data = $random(seed);
        retire(1'b0, 5'd4, data, 32'h100);
        exp_gpr[4] = data;
        halt_core("test_halt_ebreak haltreq");
        read_check("test_halt_ebreak haltreq dpc", `DBG_ADDR_DPC, 32'h104);
        read_check("test_halt_ebreak haltreq dcsr", `DBG_ADDR_DCSR, dcsr_value(3'd3));
        resume_core("test_halt_ebreak", acks, pc);
        check_value("test_halt_ebreak acks", 32'd1, 32'(acks));
        check_value("test_halt_ebreak pc", 32'h104, pc);
        retire(1'b1, 5'd3, ~exp_gpr[3], 32'h200);
        wait_halted("test_halt_ebreak ebreak", 1'b1);
        read_check("test_halt_ebreak ebreak dpc", `DBG_ADDR_DPC, 32'h200);
        read_check("test_halt_ebreak ebreak dcsr", `DBG_ADDR_DCSR, dcsr_value(3'd1));
        read_check("test_halt_ebreak ebreak x3", gpr_addr(3), exp_gpr[3]);
    endtask

    task automatic test_dpc_resume();
        logic [31:0] data;
        logic [31:0] rdata;
        logic [31:0] pc;
        int          acks;
        data = $random(seed);
        ar_access("test_dpc_resume dpc", 1'b1, `DBG_ADDR_DPC, data, rdata);
        ar_access("test_dpc_resume dcsr", 1'b1, `DBG_ADDR_DCSR, ~data, rdata);
        read_check("test_dpc_resume dcsr", `DBG_ADDR_DCSR, dcsr_value(3'd1));
        resume_core("test_dpc_resume", acks, pc);
        check_value("test_dpc_resume acks", 32'd1, 32'(acks));
        check_value("test_dpc_resume pc", data, pc);
    endtask

    // read issued in the first cycle of a back-to-back retire stream to x9
    task automatic test_retire_stream();
        logic [31:0] vals [4];
        logic [31:0] rdata;
        foreach (vals[i]) begin
            vals[i] = $random(seed);
        end
        @(posedge clk);
        dbg_ar_en_i    <= 1'b1;
        dbg_ar_wr_i    <= 1'b0;
        dbg_ar_ad_i    <= gpr_addr(9);
        retire_valid_i <= 1'b1;
        retire_rd_i    <= 5'd9;
        retire_data_i  <= vals[0];
        for (int i = 1; i < 4; i++) begin
            @(posedge clk);
            dbg_ar_en_i   <= 1'b0;
            retire_data_i <= vals[i];
        end
        @(posedge clk);
        retire_valid_i <= 1'b0;
        exp_gpr[9] = vals[3];
        wait_done("test_retire_stream", rdata);
        check_value("test_retire_stream x9", exp_gpr[9], rdata);
    endtask

    initial begin
        rst_n_i          = 1'b0;
        retire_valid_i   = 1'b0;
        retire_ebreak_i  = 1'b0;
        retire_rd_i      = '0;
        retire_data_i    = '0;
        retire_pc_i      = '0;
        retire_next_pc_i = '0;
        haltreq_i        = 1'b0;
        resumereq_i      = 1'b0;
        dbg_ar_en_i      = 1'b0;
        dbg_ar_wr_i      = 1'b0;
        dbg_ar_ad_i      = '0;
        dbg_ar_do_i      = '0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;

        test_reset();
        test_retire_readback();
        test_gpr_write();
        test_halt_ebreak();
        test_dpc_resume();
        test_retire_stream();

        @(posedge clk);
        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/dbg_pkg.sv
verilog/reg_port_if.sv
verilog/gpr_file.sv
verilog/gpr_arbiter.sv
verilog/abstract_access.sv
verilog/core_dbg_fsm.sv
verilog/dbg_top.sv
dv/dbg_props.sv
dv/dbg_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module dbg_tb -o dbg_sim

output=$(./obj_dir/dbg_sim)
echo "$output"

if echo "$output" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1

// ==== verilog/abstract_access.sv ====
`include "dbg_settings.svh"

module abstract_access
    import dbg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 dbg_ar_en_i,
    input  logic                 dbg_ar_wr_i,
    input  logic [15:0]          dbg_ar_ad_i,
    input  logic [`DBG_XLEN-1:0] dbg_ar_do_i,
    output logic [`DBG_XLEN-1:0] dbg_ar_di_o,
    output logic                 dbg_ar_done_o,
    input  logic [`DBG_XLEN-1:0] dcsr_i,
    input  logic [`DBG_XLEN-1:0] dpc_i,
    output logic                 dpc_we_o,
    output logic [`DBG_XLEN-1:0] dpc_wdata_o,
    reg_port_if.requester        rf
);

    ar_target_e           ad_target;
    logic [4:0]           ad_offset;
    logic [`DBG_XLEN-1:0] local_rdata;
    logic                 accept;

    logic                 pending_q;
    logic                 done_q;
    ar_target_e           target_q;
    logic                 wr_q;
    logic [4:0]           addr_q;
    logic [`DBG_XLEN-1:0] wdata_q;
    logic [`DBG_XLEN-1:0] di_q;

    assign ad_offset = 5'(dbg_ar_ad_i - `DBG_GPR_BASE);

    always_comb begin
        if (dbg_ar_ad_i == `DBG_ADDR_DCSR) begin
            ad_target = T_DCSR;
        end else if (dbg_ar_ad_i == `DBG_ADDR_DPC) begin
            ad_target = T_DPC;
        end else if (dbg_ar_ad_i >= `DBG_GPR_BASE &&
                     dbg_ar_ad_i < 16'(`DBG_GPR_BASE + `DBG_NUM_GPR)) begin
            ad_target = T_GPR;
        end else begin
            ad_target = T_NONE;
        end
    end

    // unmapped addresses read as zero
    always_comb begin
        case (ad_target)
            T_DCSR:  local_rdata = dcsr_i;
            T_DPC:   local_rdata = dpc_i;
            default: local_rdata = '0;
        endcase
    end

    // new requests are dropped until the done cycle has passed
    assign accept = dbg_ar_en_i && !pending_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            done_q    <= 1'b0;
        end else if (accept) begin
            pending_q <= 1'b1;
            // local registers answer right away
            done_q    <= (ad_target != T_GPR);
        end else if (done_q) begin
            pending_q <= 1'b0;
            done_q    <= 1'b0;
        end else if (rf.req && rf.gnt) begin
            done_q    <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            target_q <= ad_target;
            wr_q     <= dbg_ar_wr_i;
            addr_q   <= ad_offset;
            wdata_q  <= dbg_ar_do_i;
            di_q     <= local_rdata;
        end else if (rf.req && rf.gnt) begin
            di_q     <= rf.rdata;
        end
    end

    // gpr request stays up until the arbiter lets it through
    assign rf.req   = pending_q && !done_q && target_q == T_GPR;
    assign rf.we    = wr_q;
    assign rf.addr  = addr_q;
    assign rf.wdata = wdata_q;

    // dcsr is read only from this side
    assign dpc_we_o    = done_q && target_q == T_DPC && wr_q;
    assign dpc_wdata_o = wdata_q;

    assign dbg_ar_di_o   = di_q;
    assign dbg_ar_done_o = done_q;

endmodule

// ==== verilog/core_dbg_fsm.sv ====
`include "dbg_settings.svh"

module core_dbg_fsm
    import dbg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 haltreq_i,
    input  logic                 resumereq_i,
    input  logic                 retire_valid_i,
    input  logic                 retire_ebreak_i,
    input  logic [`DBG_XLEN-1:0] retire_pc_i,
    input  logic [`DBG_XLEN-1:0] retire_next_pc_i,
    input  logic                 dpc_we_i,
    input  logic [`DBG_XLEN-1:0] dpc_wdata_i,
    output logic                 core_running_o,
    output logic                 core_halted_o,
    output logic                 core_resumeack_o,
    output logic [`DBG_XLEN-1:0] resume_pc_o,
    output logic [`DBG_XLEN-1:0] dcsr_o,
    output logic [`DBG_XLEN-1:0] dpc_o
);

    dbg_state_e           state_q;
    halt_cause_e          cause_q;
    logic [`DBG_XLEN-1:0] dpc_q;
    logic [`DBG_XLEN-1:0] last_next_pc_q;
    logic                 resumeack_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q        <= RUNNING;
            cause_q        <= CAUSE_NONE;
            dpc_q          <= '0;
            last_next_pc_q <= '0;
            resumeack_q    <= 1'b0;
        end else begin
            resumeack_q <= 1'b0;
            case (state_q)
                RUNNING: begin
                    // track where the core would continue
                    if (retire_valid_i) begin
                        last_next_pc_q <= retire_next_pc_i;
                    end
                    if (retire_valid_i && retire_ebreak_i) begin
                        state_q <= HALTED;
                        cause_q <= EBREAK;
                        dpc_q   <= retire_pc_i;
                    end else if (haltreq_i) begin
                        state_q <= HALTED;
                        cause_q <= HALTREQ;
                        // a retire in this very cycle is the newest one
                        dpc_q   <= retire_valid_i ? retire_next_pc_i : last_next_pc_q;
                    end
                end
                HALTED: begin
                    if (dpc_we_i) begin
                        dpc_q <= dpc_wdata_i;
                    end
                    if (resumereq_i) begin
                        state_q     <= RUNNING;
                        resumeack_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    // xdebugver, cause in 8:6, machine mode in prv
    assign dcsr_o = {4'(`DBG_XDEBUGVER), 19'd0, cause_q, 4'd0, 2'b11};
    assign dpc_o  = dpc_q;

    assign core_running_o   = (state_q == RUNNING);
    assign core_halted_o    = (state_q == HALTED);
    assign core_resumeack_o = resumeack_q;
    assign resume_pc_o      = dpc_q;

endmodule

// ==== verilog/dbg_pkg.sv ====
package dbg_pkg;

    // core run state as seen by the debug module
    typedef enum logic {
        RUNNING = 1'b0,
        HALTED  = 1'b1
    } dbg_state_e;

    // encodings follow the dcsr cause field
    typedef enum logic [2:0] {
        CAUSE_NONE = 3'd0,
        EBREAK     = 3'd1,
        HALTREQ    = 3'd3
    } halt_cause_e;

    // decoded abstract register target
    typedef enum logic [1:0] {
        T_DCSR = 2'd0,
        T_DPC  = 2'd1,
        T_GPR  = 2'd2,
        T_NONE = 2'd3
    } ar_target_e;

endpackage

// ==== verilog/dbg_settings.svh ====
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// register data width and number of general registers
`define DBG_XLEN        32
`define DBG_NUM_GPR     32

// debug csr addresses seen by the abstract access port
`define DBG_ADDR_DCSR   16'h07b0
`define DBG_ADDR_DPC    16'h07b1

// gpr n lives at base + n
`define DBG_GPR_BASE    16'h1000

// external debug support version, dcsr[31:28]
`define DBG_XDEBUGVER   4

`endif

// ==== verilog/dbg_top.sv ====
`include "dbg_settings.svh"

module dbg_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 retire_valid_i,
    input  logic                 retire_ebreak_i,
    input  logic [4:0]           retire_rd_i,
    input  logic [`DBG_XLEN-1:0] retire_data_i,
    input  logic [`DBG_XLEN-1:0] retire_pc_i,
    input  logic [`DBG_XLEN-1:0] retire_next_pc_i,
    input  logic                 haltreq_i,
    input  logic                 resumereq_i,
    input  logic                 dbg_ar_en_i,
    input  logic                 dbg_ar_wr_i,
    input  logic [15:0]          dbg_ar_ad_i,
    input  logic [`DBG_XLEN-1:0] dbg_ar_do_i,
    output logic [`DBG_XLEN-1:0] dbg_ar_di_o,
    output logic                 dbg_ar_done_o,
    output logic                 core_running_o,
    output logic                 core_halted_o,
    output logic                 core_resumeack_o,
    output logic [`DBG_XLEN-1:0] resume_pc_o
);

    logic [`DBG_XLEN-1:0] dcsr;
    logic [`DBG_XLEN-1:0] dpc;
    logic                 dpc_we;
    logic [`DBG_XLEN-1:0] dpc_wdata;

    reg_port_if ar_port ();
    reg_port_if rf_port ();

    core_dbg_fsm u_core_dbg_fsm (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .haltreq_i        (haltreq_i),
        .resumereq_i      (resumereq_i),
        .retire_valid_i   (retire_valid_i),
        .retire_ebreak_i  (retire_ebreak_i),
        .retire_pc_i      (retire_pc_i),
        .retire_next_pc_i (retire_next_pc_i),
        .dpc_we_i         (dpc_we),
        .dpc_wdata_i      (dpc_wdata),
        .core_running_o   (core_running_o),
        .core_halted_o    (core_halted_o),
        .core_resumeack_o (core_resumeack_o),
        .resume_pc_o      (resume_pc_o),
        .dcsr_o           (dcsr),
        .dpc_o            (dpc)
    );

    abstract_access u_abstract_access (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .dbg_ar_en_i   (dbg_ar_en_i),
        .dbg_ar_wr_i   (dbg_ar_wr_i),
        .dbg_ar_ad_i   (dbg_ar_ad_i),
        .dbg_ar_do_i   (dbg_ar_do_i),
        .dbg_ar_di_o   (dbg_ar_di_o),
        .dbg_ar_done_o (dbg_ar_done_o),
        .dcsr_i        (dcsr),
        .dpc_i         (dpc),
        .dpc_we_o      (dpc_we),
        .dpc_wdata_o   (dpc_wdata),
        .rf            (ar_port.requester)
    );

    // an ebreak retires without a register write
    gpr_arbiter u_gpr_arbiter (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .retire_valid_i (retire_valid_i & ~retire_ebreak_i),
        .retire_rd_i    (retire_rd_i),
        .retire_data_i  (retire_data_i),
        .running_i      (core_running_o),
        .dbg_port       (ar_port.file),
        .rf_port        (rf_port.requester)
    );

    gpr_file u_gpr_file (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .port    (rf_port.file)
    );

endmodule

// ==== verilog/gpr_arbiter.sv ====
`include "dbg_settings.svh"

module gpr_arbiter (
    input logic                 clk,
    input logic                 rst_n_i,
    input logic                 retire_valid_i,
    input logic [4:0]           retire_rd_i,
    input logic [`DBG_XLEN-1:0] retire_data_i,
    input logic                 running_i,
    reg_port_if.file            dbg_port,
    reg_port_if.requester       rf_port
);

    logic retire_req;

    // writeback only counts while the core runs
    assign retire_req = retire_valid_i && running_i;

    // retire side always wins, debug gets the leftover cycles
    always_comb begin
        if (retire_req) begin
            rf_port.req   = 1'b1;
            rf_port.we    = 1'b1;
            rf_port.addr  = retire_rd_i;
            rf_port.wdata = retire_data_i;
        end else begin
            rf_port.req   = dbg_port.req;
            rf_port.we    = dbg_port.we;
            rf_port.addr  = dbg_port.addr;
            rf_port.wdata = dbg_port.wdata;
        end
    end

    assign dbg_port.gnt   = dbg_port.req && !retire_req && rf_port.gnt;
    assign dbg_port.rdata = rf_port.rdata;

endmodule

// ==== verilog/gpr_file.sv ====
`include "dbg_settings.svh"

module gpr_file (
    input logic        clk,
    input logic        rst_n_i,
    reg_port_if.file   port
);

    localparam int NUM_REGS = `DBG_NUM_GPR;

    logic [`DBG_XLEN-1:0] regs [NUM_REGS];

    // single port, nothing to wait for
    assign port.gnt = port.req;

    // x0 is hardwired to zero
    assign port.rdata = (port.addr == 5'd0) ? '0 : regs[port.addr];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (port.req && port.we && port.addr != 5'd0) begin
            regs[port.addr] <= port.wdata;
        end
    end

endmodule

// ==== verilog/reg_port_if.sv ====
`include "dbg_settings.svh"

interface reg_port_if;

    logic                 req;
    logic                 we;
    logic [4:0]           addr;
    logic [`DBG_XLEN-1:0] wdata;
    logic [`DBG_XLEN-1:0] rdata;
    logic                 gnt;

    // side that asks for the port
    modport requester (output req, we, addr, wdata, input rdata, gnt);

    // side that owns the storage
    modport file (input req, we, addr, wdata, output rdata, gnt);

endinterface
